// ==== basics_int.sv ====
`timescale 1ns/1ns
`include "ice_consts.svh"

module basics_int
	import ice_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] ma_addr,
	input  logic [7:0] ma_data,
	input  logic       ma_data_valid,
	input  logic       ma_frame_valid,
	output logic [8:0] sl_data,
	input  logic       sl_data_latch,
	output logic       sl_arb_request,
	input  logic       sl_arb_grant,
	output logic       sl_nak,
	output logic       goc_mode,
	output logic       goc_polarity,
	output logic [7:0] ein_div
);

	// Setting selectors, 'm' and 'd'
	localparam logic [7:0]  SEL_MODE = 8'h6d;
	localparam logic [7:0]  SEL_DIV  = 8'h64;
	localparam logic [15:0] VERSION  = `ICE_VERSION;

	logic       fv_d;
	logic       own;
	logic [1:0] nbytes;
	logic [7:0] sel;
	logic [7:0] val;
	logic [7:0] resp [0:2];
	logic [1:0] idx;
	logic [1:0] last_idx;
	logic       frame_start;
	logic       frame_end;
	logic       is_mode;
	logic       sel_ok;
	logic       get_ok;
	logic [7:0] rd_value;

	assign frame_start = ma_frame_valid && !fv_d;
	assign frame_end   = fv_d && !ma_frame_valid;

	// Selector check, a write needs the value byte too
	assign is_mode  = (sel == SEL_MODE);
	assign sel_ok   = (is_mode || sel == SEL_DIV) &&
		(nbytes >= ((ma_addr == MSG_SET) ? 2'd2 : 2'd1));
	assign get_ok   = (ma_addr == MSG_GET) && sel_ok;
	assign rd_value = is_mode ? {6'd0, goc_polarity, goc_mode} : ein_div;

	// Body: length byte, then payload
	assign sl_data = sl_arb_grant ? {idx == last_idx, resp[idx]} : 9'd0;

	always_ff @(posedge clk) begin
		if (ma_data_valid && own && nbytes == 2'd0) begin
			sel <= ma_data;
		end
		if (ma_data_valid && own && nbytes == 2'd1) begin
			val <= ma_data;
		end
		if (frame_end && own) begin
			resp[0] <= (ma_addr == MSG_VERSION) ? 8'd2 : {7'd0, get_ok};
			resp[1] <= (ma_addr == MSG_VERSION) ? VERSION[15:8] : rd_value;
			resp[2] <= VERSION[7:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fv_d           <= 1'b0;
			own            <= 1'b0;
			nbytes         <= '0;
			idx            <= '0;
			last_idx       <= '0;
			sl_arb_request <= 1'b0;
			sl_nak         <= 1'b0;
			goc_mode       <= 1'b0;
			goc_polarity   <= 1'b0;
			ein_div        <= `EIN_DEFAULT_DIV;
		end else begin
			fv_d <= ma_frame_valid;
			if (frame_start) begin
				own    <= ma_addr inside {MSG_VERSION, MSG_SET, MSG_GET};
				nbytes <= '0;
			end
			// Only the first two bytes matter
			if (ma_data_valid && own && nbytes != 2'd2) begin
				nbytes <= nbytes + 2'd1;
			end
			if (frame_end && own) begin
				own            <= 1'b0;
				idx            <= '0;
				sl_arb_request <= 1'b1;
				sl_nak         <= (ma_addr != MSG_VERSION) && !sel_ok;
				last_idx       <= (ma_addr == MSG_VERSION) ? 2'd2 : {1'b0, get_ok};
				if (ma_addr == MSG_SET && sel_ok && is_mode) begin
					{goc_polarity, goc_mode} <= val[1:0];
				end
				if (ma_addr == MSG_SET && sel_ok && !is_mode) begin
					ein_div <= val;
				end
			end
			// Advance as the controller takes each byte
			if (sl_data_latch && sl_arb_grant) begin
				if (idx == last_idx) begin
					sl_arb_request <= 1'b0;
				end else begin
					idx <= idx + 2'd1;
				end
			end
		end
	end

endmodule

// ==== ein_int.sv ====
`timescale 1ns/1ns

module ein_int
	import ice_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] ma_addr,
	input  logic [7:0] ma_data,
	input  logic       ma_data_valid,
	input  logic       ma_frame_valid,
	input  logic       goc_mode,
	input  logic       goc_polarity,
	input  logic [7:0] ein_div,
	output logic       emo,
	output logic       edi,
	output logic       eci,
	output logic       goc_pad,
	output logic [8:0] sl_data,
	input  logic       sl_data_latch,
	output logic       sl_arb_request,
	input  logic       sl_arb_grant,
	output logic       sl_nak
);

	logic       fv_d;
	logic       own;
	logic       shifting;
	logic [3:0] cnt;
	logic [7:0] data_mem [0:7];
	logic [2:0] byte_idx;
	logic [2:0] bit_idx;
	logic [7:0] ph_cnt;
	logic       emo_r;
	logic       edi_r;
	logic       eci_r;
	logic       last_bit;

	assign last_bit = ({1'b0, byte_idx} == cnt - 4'd1) && (bit_idx == 3'd0);

	// GOC mode moves the data onto the optical pad
	assign emo     = goc_mode ? 1'b0 : emo_r;
	assign edi     = goc_mode ? 1'b0 : edi_r;
	assign eci     = goc_mode ? 1'b0 : eci_r;
	assign goc_pad = goc_mode ? (edi_r ^ goc_polarity) : goc_polarity;

	// Body is always just length 0
	assign sl_data = sl_arb_grant ? {1'b1, 8'd0} : 9'd0;

	always_ff @(posedge clk) begin
		if (ma_data_valid && own && cnt < 4'd8) begin
			data_mem[cnt[2:0]] <= ma_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fv_d <= 1'b0;
			own <= 1'b0;
			shifting <= 1'b0;
			cnt <= '0;
			byte_idx <= '0;
			bit_idx <= '0;
			ph_cnt <= '0;
			emo_r <= 1'b0;
			edi_r <= 1'b0;
			eci_r <= 1'b0;
			sl_arb_request <= 1'b0;
			sl_nak <= 1'b0;
		end else begin
			fv_d <= ma_frame_valid;
			if (ma_frame_valid && !fv_d) begin
				own <= (ma_addr == MSG_EIN);
				cnt <= '0;
			end
			// Saturates at 9, enough to flag overflow
			if (ma_data_valid && own && cnt != 4'd9) begin
				cnt <= cnt + 4'd1;
			end
			if (fv_d && !ma_frame_valid && own) begin
				own <= 1'b0;
				sl_nak <= (cnt > 4'd8);
				if (cnt > 4'd8 || cnt == 4'd0) begin
					sl_arb_request <= 1'b1;
				end else begin
					// Burst starts, first bit MSB of byte 0
					shifting <= 1'b1;
					emo_r <= 1'b1;
					edi_r <= data_mem[0][7];
					eci_r <= 1'b0;
					ph_cnt <= ein_div;
					byte_idx <= '0;
					bit_idx <= 3'd7;
				end
			end
			// Half bit is div+1 clocks
			if (shifting) begin
				if (ph_cnt != 8'd0) begin
					ph_cnt <= ph_cnt - 8'd1;
				end else begin
					ph_cnt <= ein_div;
					eci_r <= !eci_r;
					if (eci_r && last_bit) begin
						// ACK only after the last bit
						shifting <= 1'b0;
						emo_r <= 1'b0;
						edi_r <= 1'b0;
						sl_arb_request <= 1'b1;
					end else if (eci_r && bit_idx == 3'd0) begin
						byte_idx <= byte_idx + 3'd1;
						bit_idx <= 3'd7;
						edi_r <= data_mem[byte_idx + 3'd1][7];
					end else if (eci_r) begin
						bit_idx <= bit_idx - 3'd1;
						edi_r <= data_mem[byte_idx][bit_idx - 3'd1];
					end
				end
			end
			if (sl_data_latch && sl_arb_grant) begin
				sl_arb_request <= 1'b0;
			end
		end
	end

endmodule

// ==== flist.f ====
+incdir+.
ice_pkg.sv
uart.sv
ice_bus_controller.sv
basics_int.sv
ein_int.sv
ice_bus.sv
tb_ice_bus.sv

// ==== ice_bus.sv ====
`timescale 1ns/1ns
`include "ice_consts.svh"

module ice_bus (
	input  logic clk,
	input  logic rst_n,
	input  logic uart_rxd,
	output logic uart_txd,
	output logic ein_emo,
	output logic ein_edi,
	output logic ein_eci,
	output logic goc_pad
);

	// UART byte interface
	logic [7:0] uart_rx_data;
	logic [7:0] uart_tx_data;
	logic       uart_rx_latch;
	logic       uart_tx_latch;
	logic       uart_tx_empty;

	// Master bus, slave bus
	logic [7:0]                   ma_addr;
	logic [7:0]                   ma_data;
	logic                         ma_data_valid;
	logic                         ma_frame_valid;
	logic [`ICE_NUM_DEV-1:0][8:0] sl_data;
	logic [`ICE_NUM_DEV-1:0]      sl_nak;
	logic                         sl_data_latch;
	logic [`ICE_NUM_DEV-1:0]      sl_arb_request;
	logic [`ICE_NUM_DEV-1:0]      sl_arb_grant;

	// Settings from basics to EIN
	logic       goc_mode;
	logic       goc_polarity;
	logic [7:0] ein_div;

	uart uart_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_in    (uart_rxd),
		.tx_out   (uart_txd),
		.tx_data  (uart_tx_data),
		.tx_latch (uart_tx_latch),
		.tx_empty (uart_tx_empty),
		.rx_data  (uart_rx_data),
		.rx_latch (uart_rx_latch)
	);

	ice_bus_controller ctrl_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.rx_char        (uart_rx_data),
		.rx_char_valid  (uart_rx_latch),
		.tx_char        (uart_tx_data),
		.tx_char_valid  (uart_tx_latch),
		.tx_char_ready  (uart_tx_empty),
		.ma_addr        (ma_addr),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.sl_data        (sl_data),
		.sl_nak         (sl_nak),
		.sl_data_latch  (sl_data_latch),
		.sl_arb_request (sl_arb_request),
		.sl_arb_grant   (sl_arb_grant)
	);

	// Slot 0, top priority
	basics_int basics_inst (
		.sl_data        (sl_data[0]),
		.sl_arb_request (sl_arb_request[0]),
		.sl_arb_grant   (sl_arb_grant[0]),
		.sl_nak         (sl_nak[0]),
		.*
	);

	// Slot 1
	ein_int ein_inst (
		.emo            (ein_emo),
		.edi            (ein_edi),
		.eci            (ein_eci),
		.sl_data        (sl_data[1]),
		.sl_arb_request (sl_arb_request[1]),
		.sl_arb_grant   (sl_arb_grant[1]),
		.sl_nak         (sl_nak[1]),
		.*
	);

endmodule

// ==== ice_bus_controller.sv ====
`timescale 1ns/1ns
`include "ice_consts.svh"

module ice_bus_controller
	import ice_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [7:0]                   rx_char,
	input  logic                         rx_char_valid,
	output logic [7:0]                   tx_char,
	output logic                         tx_char_valid,
	input  logic                         tx_char_ready,
	output logic [7:0]                   ma_addr,
	output logic [7:0]                   ma_data,
	output logic                         ma_data_valid,
	output logic                         ma_frame_valid,
	input  logic [`ICE_NUM_DEV-1:0][8:0] sl_data,
	input  logic [`ICE_NUM_DEV-1:0]      sl_nak,
	output logic                         sl_data_latch,
	input  logic [`ICE_NUM_DEV-1:0]      sl_arb_request,
	output logic [`ICE_NUM_DEV-1:0]      sl_arb_grant
);

	// Receive states
	localparam logic [2:0] R_TYPE = 3'd0;
	localparam logic [2:0] R_ID   = 3'd1;
	localparam logic [2:0] R_LEN  = 3'd2;
	localparam logic [2:0] R_DATA = 3'd3;
	localparam logic [2:0] R_END  = 3'd4;

	// Transmit states
	localparam logic [2:0] T_IDLE    = 3'd0;
	localparam logic [2:0] T_ID      = 3'd1;
	localparam logic [2:0] T_BODY    = 3'd2;
	localparam logic [2:0] T_NAK_LEN = 3'd3;
	localparam logic [2:0] T_DONE    = 3'd4;

	logic [2:0]              rx_state;
	logic [2:0]              tx_state;
	logic [7:0]              rx_len;
	logic [7:0]              evt_id;
	logic                    generate_nak;
	logic                    nak_pending;
	logic                    tx_nak_mode;
	logic                    send_ok;
	logic                    known_type;
	logic [`ICE_NUM_DEV-1:0] req_pick;
	logic [8:0]              body;

	// Types some slave answers
	assign known_type = ma_addr inside {MSG_VERSION, MSG_SET, MSG_GET, MSG_EIN};

	// tx_empty lags the load by a cycle
	assign send_ok = tx_char_ready && !tx_char_valid;

	// Lowest index wins
	assign req_pick = sl_arb_request & (~sl_arb_request + 1'b1);

	// Idle slaves drive zero
	always_comb begin
		body = '0;
		for (int i = 0; i < `ICE_NUM_DEV; i++) begin
			body = body | sl_data[i];
		end
	end

	// Frame parser, master bus strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state       <= R_TYPE;
			rx_len         <= '0;
			ma_frame_valid <= 1'b0;
			ma_data_valid  <= 1'b0;
			generate_nak   <= 1'b0;
		end else begin
			ma_data_valid <= 1'b0;
			generate_nak  <= 1'b0;
			case (rx_state)
				R_TYPE: begin
					if (rx_char_valid) begin
						rx_state <= R_ID;
					end
				end
				R_ID: begin
					if (rx_char_valid) begin
						rx_state <= R_LEN;
					end
				end
				R_LEN: begin
					if (rx_char_valid) begin
						rx_len         <= rx_char;
						ma_frame_valid <= 1'b1;
						rx_state       <= (rx_char == 8'd0) ? R_END : R_DATA;
					end
				end
				R_DATA: begin
					if (rx_char_valid) begin
						ma_data_valid <= 1'b1;
						rx_len        <= rx_len - 8'd1;
						if (rx_len == 8'd1) begin
							rx_state <= R_END;
						end
					end
				end
				default: begin
					// Frame done, nobody owns it
					ma_frame_valid <= 1'b0;
					generate_nak   <= !known_type;
					rx_state       <= R_TYPE;
				end
			endcase
		end
	end

	// Header bytes and data
	always_ff @(posedge clk) begin
		if (rx_char_valid) begin
			case (rx_state)
				R_TYPE:  ma_addr <= rx_char;
				R_ID:    evt_id <= rx_char;
				R_DATA:  ma_data <= rx_char;
				default: ;
			endcase
		end
	end

	// Response: type, event id, then slave body
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_state      <= T_IDLE;
			tx_char       <= '0;
			tx_char_valid <= 1'b0;
			sl_data_latch <= 1'b0;
			sl_arb_grant  <= '0;
			nak_pending   <= 1'b0;
			tx_nak_mode   <= 1'b0;
		end else begin
			tx_char_valid <= 1'b0;
			sl_data_latch <= 1'b0;
			case (tx_state)
				T_IDLE: begin
					// Immediate NAK beats the arbiter
					if (send_ok && nak_pending) begin
						tx_char       <= `ICE_NAK;
						tx_char_valid <= 1'b1;
						nak_pending   <= 1'b0;
						tx_nak_mode   <= 1'b1;
						tx_state      <= T_ID;
					end else if (send_ok && sl_arb_request != '0) begin
						sl_arb_grant  <= req_pick;
						tx_char       <= ((sl_nak & req_pick) != '0) ? `ICE_NAK : `ICE_ACK;
						tx_char_valid <= 1'b1;
						tx_nak_mode   <= 1'b0;
						tx_state      <= T_ID;
					end
				end
				T_ID: begin
					if (send_ok) begin
						tx_char       <= evt_id;
						tx_char_valid <= 1'b1;
						tx_state      <= tx_nak_mode ? T_NAK_LEN : T_BODY;
					end
				end
				T_NAK_LEN: begin
					if (send_ok) begin
						tx_char       <= 8'd0;
						tx_char_valid <= 1'b1;
						tx_state      <= T_IDLE;
					end
				end
				T_BODY: begin
					if (send_ok) begin
						tx_char       <= body[7:0];
						tx_char_valid <= 1'b1;
						sl_data_latch <= 1'b1;
						// Bit 8 flags the last byte
						if (body[8]) begin
							tx_state <= T_DONE;
						end
					end
				end
				default: begin
					// Grant held through the last latch
					sl_arb_grant <= '0;
					tx_state     <= T_IDLE;
				end
			endcase
			if (generate_nak) begin
				nak_pending <= 1'b1;
			end
		end
	end

endmodule

// ==== ice_consts.svh ====
`ifndef ICE_CONSTS_SVH
`define ICE_CONSTS_SVH

// Slave ports on the arbiter
// Index 0 is basics and wins, index 1 is EIN
`define ICE_NUM_DEV 2

// Answer to the version query
`define ICE_VERSION 16'h0102

// Response type bytes
`define ICE_ACK 8'h00
`define ICE_NAK 8'h01

// Clocks per UART bit
`define UART_DIV 16'd8

// EIN divider after reset
`define EIN_DEFAULT_DIV 8'd3

`endif

// ==== ice_pkg.sv ====
package ice_pkg;

	// Frame type byte, first byte of every host frame
	typedef enum logic [7:0] {
		// 'V', version query
		MSG_VERSION = 8'h56,
		// 'O', setting write
		MSG_SET     = 8'h4f,
		// 'o', setting read
		MSG_GET     = 8'h6f,
		// 'e', EIN/GOC burst
		MSG_EIN     = 8'h65
	} ice_msg_t;

endpackage

// ==== tb_ice_bus.sv ====
`timescale 1ns/1ns
`include "ice_consts.svh"

module tb_ice_bus
	import ice_pkg::*;
();

	// Selectors as the host sends them
	localparam logic [7:0]  SEL_MODE     = 8'h6d;
	localparam logic [7:0]  SEL_DIV      = 8'h64;
	localparam logic [7:0]  TYPE_UNKNOWN = 8'h5a;
	localparam logic [15:0] VERSION      = `ICE_VERSION;
	// Clocks allowed for one wait
	localparam int WAIT_LIMIT = 3000;

	logic clk;
	logic rst_n;
	logic uart_rxd;
	logic uart_txd;
	logic ein_emo;
	logic ein_edi;
	logic ein_eci;
	logic goc_pad;

	integer seed;
	int     errors;
	int     cur_div;

	// Host payload, response seen, response expected
	logic [7:0] tx_buf [0:15];
	logic [7:0] rsp [0:15];
	int         rsp_len;
	logic [7:0] exp_buf [0:15];
	int         exp_len;

	// Bits seen on the pads
	logic bit_buf [0:127];
	int   bit_cnt;
	int   emo_low;
	logic goc_watch;
	logic pad_seen;

	ice_bus ice_bus_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.uart_rxd (uart_rxd),
		.uart_txd (uart_txd),
		.ein_emo  (ein_emo),
		.ein_edi  (ein_edi),
		.ein_eci  (ein_eci),
		.goc_pad  (goc_pad)
	);

	always #20 clk = ~clk;

	// EDI only moves while ECI is low
	always @(posedge ein_eci) begin
		if (bit_cnt < 128) begin
			bit_buf[bit_cnt] = ein_edi;
		end
		bit_cnt++;
		if (ein_emo !== 1'b1) begin
			emo_low++;
		end
	end

	// Three-wire pads must stay quiet in GOC mode
	always @(negedge clk) begin
		if (goc_watch && (ein_emo !== 1'b0 || ein_edi !== 1'b0 || ein_eci !== 1'b0)) begin
			pad_seen = 1'b1;
		end
	end

	task report_mismatch(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
		$display("Error %s expected %0h got %0h", name, exp_v, got_v);
		errors++;
	endtask

	task report_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	task stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Run stopped with %0d errors", errors + 1);
		$display("Something failed");
		$finish;
	endtask

	// 8N1, LSB first, one idle bit after the stop bit
	task send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#2;
			uart_rxd = bits[i];
			repeat (`UART_DIV - 1) @(posedge clk);
		end
		repeat (`UART_DIV) @(posedge clk);
	endtask

	task send_frame(input logic [7:0] typ, input logic [7:0] id, input int n);
		send_byte(typ);
		send_byte(id);
		send_byte(n[7:0]);
		for (int i = 0; i < n; i++) begin
			send_byte(tx_buf[i]);
		end
	endtask

	// Sampled on falling edges, away from the DUT's updates
	task get_byte(output logic [7:0] b);
		int n;
		n = 0;
		b = '0;
		@(negedge clk);
		while (uart_txd !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			stop_on_timeout("a response byte");
		end else begin
			// Middle of the start bit
			repeat (`UART_DIV / 2) @(negedge clk);
			if (uart_txd !== 1'b0) begin
				report_failure("Start bit on uart_txd too short");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (`UART_DIV) @(negedge clk);
				b[i] = uart_txd;
			end
			repeat (`UART_DIV) @(negedge clk);
			if (uart_txd !== 1'b1) begin
				report_failure("Stop bit missing on uart_txd");
			end
		end
	endtask

	// Type, id, length, then body
	task get_response();
		logic [7:0] b;
		int         n;
		for (int i = 0; i < 3; i++) begin
			get_byte(b);
			rsp[i] = b;
		end
		// Bad length capped at the buffer
		n = (rsp[2] > 8'd12) ? 12 : int'(rsp[2]);
		for (int i = 0; i < n; i++) begin
			get_byte(b);
			rsp[3 + i] = b;
		end
		rsp_len = 3 + n;
	endtask

	// Response may start before the host's last stop bit ends
	task run_frame(input logic [7:0] typ, input logic [7:0] id, input int n);
		fork
			send_frame(typ, id, n);
			get_response();
		join
	endtask

	task expect_header(input logic [7:0] typ, input logic [7:0] id, input logic [7:0] len);
		exp_buf[0] = typ;
		exp_buf[1] = id;
		exp_buf[2] = len;
		exp_len = 3 + len;
	endtask

	task compare_resp(input string name);
		if (rsp_len != exp_len) begin
			report_mismatch($sformatf("%s length", name), exp_len, rsp_len);
		end
		for (int i = 0; i < exp_len && i < rsp_len; i++) begin
			if (rsp[i] !== exp_buf[i]) begin
				report_mismatch($sformatf("%s byte %0d", name, i), exp_buf[i], rsp[i]);
			end
		end
	endtask

	// GOC has no clock pad, so bits are timed from the first edge
	task sample_goc(input int nbits);
		int n;
		n = 0;
		@(negedge clk);
		while (goc_pad !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			stop_on_timeout("the GOC burst");
		end else begin
			// Half a bit in, where ECI would rise
			repeat (cur_div + 1) @(negedge clk);
			for (int k = 0; k < nbits; k++) begin
				bit_buf[k] = goc_pad;
				repeat (2 * (cur_div + 1)) @(negedge clk);
			end
		end
	endtask

	task test_reset_idle();
		logic start_seen;
		start_seen = 1'b0;
		@(negedge clk);
		if (uart_txd !== 1'b1) begin
			report_mismatch("reset_idle uart_txd", 1, uart_txd);
		end
		if (ein_emo !== 1'b0) begin
			report_mismatch("reset_idle ein_emo", 0, ein_emo);
		end
		if (ein_edi !== 1'b0) begin
			report_mismatch("reset_idle ein_edi", 0, ein_edi);
		end
		if (ein_eci !== 1'b0) begin
			report_mismatch("reset_idle ein_eci", 0, ein_eci);
		end
		if (goc_pad !== 1'b0) begin
			report_mismatch("reset_idle goc_pad", 0, goc_pad);
		end
		repeat (300) begin
			@(negedge clk);
			if (uart_txd !== 1'b1) begin
				start_seen = 1'b1;
			end
		end
		if (start_seen) begin
			report_failure("A byte left on uart_txd while idle after reset");
		end
	endtask

	task test_version(input string name, input logic [7:0] id);
		run_frame(MSG_VERSION, id, 0);
		expect_header(`ICE_ACK, id, 8'd2);
		// High byte first
		exp_buf[3] = VERSION[15:8];
		exp_buf[4] = VERSION[7:0];
		compare_resp(name);
	endtask

	task test_unknown_type();
		tx_buf[0] = 8'h11;
		tx_buf[1] = 8'h22;
		run_frame(TYPE_UNKNOWN, 8'h33, 2);
		expect_header(`ICE_NAK, 8'h33, 8'd0);
		compare_resp("unknown_type");
		test_version("version_after_nak", 8'h34);
	endtask

	task test_settings();
		tx_buf[0] = SEL_DIV;
		tx_buf[1] = 8'd5;
		run_frame(MSG_SET, 8'h40, 2);
		expect_header(`ICE_ACK, 8'h40, 8'd0);
		compare_resp("set_div");
		cur_div = 5;
		tx_buf[0] = SEL_DIV;
		run_frame(MSG_GET, 8'h41, 1);
		expect_header(`ICE_ACK, 8'h41, 8'd1);
		exp_buf[3] = 8'd5;
		compare_resp("get_div");
		// 'q' is no selector
		tx_buf[0] = 8'h71;
		tx_buf[1] = 8'h01;
		run_frame(MSG_SET, 8'h42, 2);
		expect_header(`ICE_NAK, 8'h42, 8'd0);
		compare_resp("set_unknown");
	endtask

	task test_ein_burst();
		logic [31:0] rnd;
		logic        exp_bit;
		for (int i = 0; i < 3; i++) begin
			rnd = $random(seed);
			tx_buf[i] = rnd[7:0];
		end
		bit_cnt = 0;
		emo_low = 0;
		run_frame(MSG_EIN, 8'h50, 3);
		expect_header(`ICE_ACK, 8'h50, 8'd0);
		compare_resp("ein_burst");
		if (bit_cnt != 24) begin
			report_mismatch("ein_burst bit count", 24, bit_cnt);
		end
		// MSB first, byte 0 first
		for (int k = 0; k < 24 && k < bit_cnt; k++) begin
			exp_bit = tx_buf[k / 8][7 - k % 8];
			if (bit_buf[k] !== exp_bit) begin
				report_mismatch($sformatf("ein_burst bit %0d", k), exp_bit, bit_buf[k]);
			end
		end
		if (emo_low != 0) begin
			report_failure("ein_emo was low during the EIN burst");
		end
	endtask

	task test_goc_mode();
		logic [31:0] rnd;
		logic        exp_bit;
		// Mode 3, GOC on with inverted polarity
		tx_buf[0] = SEL_MODE;
		tx_buf[1] = 8'd3;
		run_frame(MSG_SET, 8'h60, 2);
		expect_header(`ICE_ACK, 8'h60, 8'd0);
		compare_resp("set_mode");
		@(negedge clk);
		if (goc_pad !== 1'b1) begin
			report_mismatch("goc_rest_before", 1, goc_pad);
		end
		// Leading 1 marks the burst start on the pad
		rnd = $random(seed);
		tx_buf[0] = rnd[7:0] | 8'h80;
		rnd = $random(seed);
		tx_buf[1] = rnd[7:0];
		pad_seen = 1'b0;
		goc_watch = 1'b1;
		fork
			send_frame(MSG_EIN, 8'h61, 2);
			get_response();
			sample_goc(16);
		join
		goc_watch = 1'b0;
		expect_header(`ICE_ACK, 8'h61, 8'd0);
		compare_resp("goc_burst");
		for (int k = 0; k < 16; k++) begin
			exp_bit = ~tx_buf[k / 8][7 - k % 8];
			if (bit_buf[k] !== exp_bit) begin
				report_mismatch($sformatf("goc_burst bit %0d", k), exp_bit, bit_buf[k]);
			end
		end
		if (pad_seen) begin
			report_failure("EIN pads were active in GOC mode");
		end
		@(negedge clk);
		if (goc_pad !== 1'b1) begin
			report_mismatch("goc_rest_after", 1, goc_pad);
		end
		// One byte more than the buffer holds
		for (int i = 0; i < 9; i++) begin
			rnd = $random(seed);
			tx_buf[i] = rnd[7:0];
		end
		run_frame(MSG_EIN, 8'h62, 9);
		expect_header(`ICE_NAK, 8'h62, 8'd0);
		compare_resp("goc_overflow");
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		uart_rxd = 1'b1;
		seed = 32'hce53;
		errors = 0;
		cur_div = `EIN_DEFAULT_DIV;
		bit_cnt = 0;
		emo_low = 0;
		goc_watch = 1'b0;
		pad_seen = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset_idle();
		test_version("version", 8'h21);
		test_unknown_type();
		test_settings();
		test_ein_burst();
		test_goc_mode();
		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== uart.sv ====
`timescale 1ns/1ns
`include "ice_consts.svh"

module uart (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_in,
	output logic       tx_out,
	input  logic [7:0] tx_data,
	input  logic       tx_latch,
	output logic       tx_empty,
	output logic [7:0] rx_data,
	output logic       rx_latch
);

	localparam logic [15:0] HALF_DIV = `UART_DIV / 2;

	// Receiver state
	logic        rx_meta;
	logic        rx_sync;
	logic        rx_busy;
	logic [15:0] rx_cnt;
	logic [3:0]  rx_bits;
	logic [7:0]  rx_shift;

	// Transmitter state
	logic [8:0]  tx_shift;
	logic [3:0]  tx_bits;
	logic [15:0] tx_cnt;

	// Two flops for the async line, idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_in;
			rx_sync <= rx_meta;
		end
	end

	// rx_bits: 0 start, 1..8 data, 9 stop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_busy  <= 1'b0;
			rx_cnt   <= '0;
			rx_bits  <= '0;
			rx_latch <= 1'b0;
		end else begin
			rx_latch <= 1'b0;
			if (!rx_busy) begin
				// Start bit edge, wait half a bit
				if (!rx_sync) begin
					rx_busy <= 1'b1;
					rx_cnt  <= HALF_DIV - 16'd1;
					rx_bits <= 4'd0;
				end
			end else if (rx_cnt != 16'd0) begin
				rx_cnt <= rx_cnt - 16'd1;
			end else begin
				// Mid-bit sample point
				rx_cnt  <= `UART_DIV - 16'd1;
				rx_bits <= rx_bits + 4'd1;
				if (rx_bits == 4'd0 && rx_sync) begin
					// Glitch on the line
					rx_busy <= 1'b0;
				end else if (rx_bits == 4'd9) begin
					rx_busy  <= 1'b0;
					// Framing error drops the byte
					rx_latch <= rx_sync;
				end
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (rx_busy && rx_cnt == 16'd0 && rx_bits != 4'd0 && rx_bits != 4'd9) begin
			rx_shift <= {rx_sync, rx_shift[7:1]};
		end
		if (rx_busy && rx_cnt == 16'd0 && rx_bits == 4'd9 && rx_sync) begin
			rx_data <= rx_shift;
		end
	end

	// tx_bits counts what is still to go after the current bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_out   <= 1'b1;
			tx_empty <= 1'b1;
			tx_bits  <= '0;
			tx_cnt   <= '0;
		end else if (tx_empty) begin
			if (tx_latch) begin
				// Start bit right away
				tx_out   <= 1'b0;
				tx_empty <= 1'b0;
				tx_bits  <= 4'd9;
				tx_cnt   <= `UART_DIV - 16'd1;
			end
		end else if (tx_cnt != 16'd0) begin
			tx_cnt <= tx_cnt - 16'd1;
		end else begin
			tx_cnt <= `UART_DIV - 16'd1;
			if (tx_bits == 4'd0) begin
				// End of stop bit
				tx_empty <= 1'b1;
			end else begin
				tx_out  <= tx_shift[0];
				tx_bits <= tx_bits - 4'd1;
			end
		end
	end

	// Data LSB first, stop bit on top
	always_ff @(posedge clk) begin
		if (tx_empty && tx_latch) begin
			tx_shift <= {1'b1, tx_data};
		end else if (!tx_empty && tx_cnt == 16'd0 && tx_bits != 4'd0) begin
			tx_shift <= {1'b1, tx_shift[8:1]};
		end
	end

endmodule
